// ==== logic/jpeg_out_defines.svh ====
`ifndef JPEG_OUT_DEFINES_SVH
`define JPEG_OUT_DEFINES_SVH

// width of a packed output word
`define JO_WORD_W 32

// codeword length field, wide enough to hold 0 to 32
`define JO_CODE_LEN_W 6

// width of one output byte
`define JO_BYTE_W 8

// words the splitter can hold
`define JO_WORD_FIFO_DEPTH 4

// bytes the stuffer can hold
`define JO_BYTE_FIFO_DEPTH 8

// cycles after frame end before frame-active drops
// must exceed the worst case time for the last word to leave the stuffer
`define JO_DRAIN_CYCLES 256

`endif

// ==== logic/jpeg_out_pkg.sv ====
`default_nettype none

`include "jpeg_out_defines.svh"

package jpeg_out_pkg;

    // one entropy coded codeword
    // only the low len bits of bits are meaningful, the highest of those goes out first
    typedef struct packed {
        logic [`JO_CODE_LEN_W-1:0] len;
        logic [`JO_WORD_W-1:0]     bits;
    } code_t;

    // a packed output word, bit 31 holds the oldest bit
    typedef logic [`JO_WORD_W-1:0] word_t;

    // end of frame sequence
    // idle passes codes through, flush pads with ones, clear empties the packer
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_flush = 2'd1,
        st_clear = 2'd2
    } flush_state_t;

endpackage

`default_nettype wire

// ==== logic/bit_packer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "jpeg_out_defines.svh"

// accumulates variable length codewords and emits them as 32-bit words
module bit_packer (
    input  logic                clock,
    input  logic                nreset,
    input  logic                clear_i,
    input  logic                code_valid_i,
    input  jpeg_out_pkg::code_t code_i,
    output logic                word_valid_o,
    output jpeg_out_pkg::word_t word_o
);
    localparam int word_w = `JO_WORD_W;
    // holds up to 31 leftover bits plus one full codeword
    localparam int acc_w  = 2 * `JO_WORD_W - 1;
    localparam int fill_w = $clog2(acc_w + 1);
    localparam logic [fill_w:0] full_fill = (fill_w + 1)'(word_w);

    // pending bits are kept left aligned, the oldest one sits in the top bit
    logic [acc_w-1:0]  acc_q;
    logic [fill_w-1:0] fill_q;

    logic [word_w-1:0] code_aligned;
    logic [acc_w-1:0]  merged;
    logic [fill_w:0]   fill_sum;
    logic [fill_w:0]   fill_left;
    logic              word_ready;

    //////////////////////////////
    // append logic
    //////////////////////////////

    always_comb begin
        // move the meaningful low bits up so the first bit to send lands in the top bit
        code_aligned = code_i.bits << (word_w - int'(code_i.len));
        // then slide the code down behind the bits already pending
        merged       = acc_q | ({code_aligned, {(acc_w - word_w){1'b0}}} >> fill_q);
        fill_sum     = {1'b0, fill_q} + (fill_w + 1)'(code_i.len);
        fill_left    = fill_sum - full_fill;
        word_ready   = code_valid_i && (fill_sum >= full_fill);
    end

    //////////////////////////////
    // pending bits and word out
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (nreset) begin
            acc_q        <= '0;
            fill_q       <= '0;
            word_valid_o <= 1'b0;
        end else begin
            word_valid_o <= word_ready;
            if (clear_i) begin
                // end of frame, whatever is left over belongs to no word
                acc_q  <= '0;
                fill_q <= '0;
            end else if (word_ready) begin
                // the oldest 32 bits leave, the remainder moves up to the top
                acc_q  <= merged << word_w;
                fill_q <= fill_left[fill_w-1:0];
            end else if (code_valid_i) begin
                acc_q  <= merged;
                fill_q <= fill_sum[fill_w-1:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (word_ready) begin
            word_o <= merged[acc_w-1 -: word_w];
        end
    end

endmodule

`default_nettype wire

// ==== logic/frame_end_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "jpeg_out_defines.svh"

// end of frame handling
// pads the packer with ones, clears it, and holds frame-active until the pipeline has drained
module frame_end_ctrl (
    input  logic                clock,
    input  logic                nreset,
    input  logic                frame_done_i,
    input  logic                code_valid_i,
    input  jpeg_out_pkg::code_t code_i,
    input  logic                word_valid_i,
    output logic                pack_valid_o,
    output jpeg_out_pkg::code_t pack_code_o,
    output logic                packer_clear_o,
    output logic                frame_active_o
);
    import jpeg_out_pkg::*;

    localparam int drain_w = $clog2(`JO_DRAIN_CYCLES + 1);
    localparam logic [drain_w-1:0] drain_max = drain_w'(`JO_DRAIN_CYCLES);

    flush_state_t       state_q;
    flush_state_t       state_d;
    logic [drain_w-1:0] drain_cnt_q;
    logic               drain_done;

    assign drain_done = (drain_cnt_q == drain_max);

    //////////////////////////////
    // flush FSM
    //////////////////////////////

    always_comb begin
        state_d      = state_q;
        pack_valid_o = 1'b0;
        pack_code_o  = code_i;
        case (state_q)
            st_idle: begin
                pack_valid_o = code_valid_i;
                if (frame_done_i) begin
                    state_d = st_flush;
                end
            end
            st_flush: begin
                // a full word of ones completes any partial word
                pack_valid_o     = 1'b1;
                pack_code_o.len  = `JO_CODE_LEN_W'(`JO_WORD_W);
                pack_code_o.bits = '1;
                state_d          = st_clear;
            end
            st_clear: begin
                if (drain_done) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            state_q        <= st_idle;
            packer_clear_o <= 1'b0;
        end else begin
            state_q        <= state_d;
            // one cycle pulse on entry to clear, after the pad has gone in
            packer_clear_o <= (state_q == st_flush);
        end
    end

    //////////////////////////////
    // drain timer and frame flag
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (nreset) begin
            drain_cnt_q    <= '0;
            frame_active_o <= 1'b0;
        end else begin
            if (state_q == st_idle) begin
                drain_cnt_q <= frame_done_i ? drain_w'(1) : '0;
            end else if (!drain_done) begin
                drain_cnt_q <= drain_cnt_q + drain_w'(1);
            end

            // any packed word means a frame is on its way out
            if (word_valid_i) begin
                frame_active_o <= 1'b1;
            end else if ((state_q == st_clear) && drain_done) begin
                frame_active_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/word_to_byte.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "jpeg_out_defines.svh"

// buffers packed words and sends them out one byte per cycle, most significant byte first
module word_to_byte (
    input  logic                  clock,
    input  logic                  nreset,
    input  logic                  word_valid_i,
    input  jpeg_out_pkg::word_t   word_i,
    output logic                  byte_valid_o,
    output logic [`JO_BYTE_W-1:0] byte_o
);
    import jpeg_out_pkg::*;

    localparam int depth     = `JO_WORD_FIFO_DEPTH;
    localparam int ptr_w     = $clog2(depth);
    localparam int cnt_w     = $clog2(depth + 1);
    localparam int bytes     = `JO_WORD_W / `JO_BYTE_W;
    localparam int idx_w     = $clog2(bytes);
    localparam logic [idx_w-1:0] last_idx = idx_w'(bytes - 1);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);

    word_t             mem [depth];
    logic [ptr_w-1:0]  wr_ptr_q;
    logic [ptr_w-1:0]  rd_ptr_q;
    logic [cnt_w-1:0]  count_q;
    logic [idx_w-1:0]  idx_q;

    word_t             head_word;
    logic              pop;

    //////////////////////////////
    // byte select
    //////////////////////////////

    assign head_word    = mem[rd_ptr_q];
    assign byte_valid_o = (count_q != '0);
    assign byte_o       = head_word[(bytes - 1 - int'(idx_q)) * `JO_BYTE_W +: `JO_BYTE_W];

    // the head word leaves after its last byte has been sent
    assign pop = byte_valid_o && (idx_q == last_idx);

    //////////////////////////////
    // word FIFO
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (word_valid_i) begin
            mem[wr_ptr_q] <= word_i;
        end
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            idx_q    <= '0;
        end else begin
            if (word_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == last_ptr) ? '0 : wr_ptr_q + ptr_w'(1);
            end
            if (byte_valid_o) begin
                idx_q <= pop ? '0 : idx_q + idx_w'(1);
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == last_ptr) ? '0 : rd_ptr_q + ptr_w'(1);
            end
            if (word_valid_i && !pop) begin
                count_q <= count_q + cnt_w'(1);
            end else if (pop && !word_valid_i) begin
                count_q <= count_q - cnt_w'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/byte_stuffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "jpeg_out_defines.svh"

// JPEG byte stuffing, every 0xff on the output is followed by a 0x00
module byte_stuffer (
    input  logic                  clock,
    input  logic                  nreset,
    input  logic                  byte_valid_i,
    input  logic [`JO_BYTE_W-1:0] byte_i,
    output logic                  byte_valid_o,
    output logic [`JO_BYTE_W-1:0] byte_o
);
    localparam int depth = `JO_BYTE_FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);

    logic [`JO_BYTE_W-1:0] mem [depth];
    logic [ptr_w-1:0]      wr_ptr_q;
    logic [ptr_w-1:0]      rd_ptr_q;
    logic [cnt_w-1:0]      count_q;
    // set after an 0xff has left, the next output slot belongs to the 0x00
    logic                  stuff_q;

    logic                  pop;

    assign pop          = !stuff_q && (count_q != '0);
    assign byte_valid_o = stuff_q || (count_q != '0);
    assign byte_o       = stuff_q ? '0 : mem[rd_ptr_q];

    //////////////////////////////
    // byte FIFO
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (byte_valid_i) begin
            mem[wr_ptr_q] <= byte_i;
        end
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            stuff_q  <= 1'b0;
        end else begin
            if (byte_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == last_ptr) ? '0 : wr_ptr_q + ptr_w'(1);
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == last_ptr) ? '0 : rd_ptr_q + ptr_w'(1);
            end
            stuff_q <= pop && (mem[rd_ptr_q] == '1);
            if (byte_valid_i && !pop) begin
                count_q <= count_q + cnt_w'(1);
            end else if (pop && !byte_valid_i) begin
                count_q <= count_q - cnt_w'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/jpeg_stream_out.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "jpeg_out_defines.svh"

// output end of the compressor, codewords in and stuffed JPEG bytes out
module jpeg_stream_out (
    input  logic                  clock,
    input  logic                  nreset,
    input  logic                  code_valid_i,
    input  jpeg_out_pkg::code_t   code_i,
    input  logic                  frame_done_i,
    output logic                  byte_valid_o,
    output logic [`JO_BYTE_W-1:0] byte_o,
    output logic                  frame_active_o
);
    import jpeg_out_pkg::*;

    code_t                 pack_code;
    logic                  pack_valid;
    logic                  packer_clear;
    word_t                 word;
    logic                  word_valid;
    logic [`JO_BYTE_W-1:0] split_byte;
    logic                  split_valid;

    //////////////////////////////
    // pipeline
    //////////////////////////////

    frame_end_ctrl u_frame_end (
        .clock          (clock),
        .nreset         (nreset),
        .frame_done_i   (frame_done_i),
        .code_valid_i   (code_valid_i),
        .code_i         (code_i),
        .word_valid_i   (word_valid),
        .pack_valid_o   (pack_valid),
        .pack_code_o    (pack_code),
        .packer_clear_o (packer_clear),
        .frame_active_o (frame_active_o)
    );

    bit_packer u_packer (
        .clock        (clock),
        .nreset       (nreset),
        .clear_i      (packer_clear),
        .code_valid_i (pack_valid),
        .code_i       (pack_code),
        .word_valid_o (word_valid),
        .word_o       (word)
    );

    word_to_byte u_splitter (
        .clock        (clock),
        .nreset       (nreset),
        .word_valid_i (word_valid),
        .word_i       (word),
        .byte_valid_o (split_valid),
        .byte_o       (split_byte)
    );

    byte_stuffer u_stuffer (
        .clock        (clock),
        .nreset       (nreset),
        .byte_valid_i (split_valid),
        .byte_i       (split_byte),
        .byte_valid_o (byte_valid_o),
        .byte_o       (byte_o)
    );

endmodule

`default_nettype wire

// ==== dv/stream_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module stream_assert (
    input logic clock,
    input logic nreset,
    input logic code_valid_i,
    input logic byte_valid_i,
    input logic frame_active_i
);
    // cycles since the last code strobe, saturating
    logic [3:0] since_code_q;
    int         fail_count = 0;

    always_ff @(posedge clock) begin
        if (nreset) begin
            since_code_q <= '1;
        end else if (code_valid_i) begin
            since_code_q <= '0;
        end else if (since_code_q != '1) begin
            since_code_q <= since_code_q + 4'd1;
        end
    end

    valid_known: assert property (@(posedge clock) disable iff (nreset)
        !$isunknown(byte_valid_i))
        else begin
            $error("byte_valid_o is unknown");
            fail_count++;
        end

    active_holds: assert property (@(posedge clock) disable iff (nreset)
        byte_valid_i |-> frame_active_i)
        else begin
            $error("frame_active_o low while a byte is sent");
            fail_count++;
        end

    code_spacing: assert property (@(posedge clock) disable iff (nreset)
        code_valid_i |-> (since_code_q >= 4'd7))
        else begin
            $error("code strobes closer than 8 cycles");
            fail_count++;
        end

endmodule

bind jpeg_stream_out stream_assert u_assert (
    .clock          (clock),
    .nreset         (nreset),
    .code_valid_i   (code_valid_i),
    .byte_valid_i   (byte_valid_o),
    .frame_active_i (frame_active_o)
);

`default_nettype wire

// ==== dv/stream_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "jpeg_out_defines.svh"

// reference model of the output stream that is compared byte by byte against the DUT
module stream_checker (
    input  logic                  clock,
    input  logic                  nreset,
    input  logic                  code_valid_i,
    input  jpeg_out_pkg::code_t   code_i,
    input  logic                  frame_done_i,
    input  logic                  byte_valid_i,
    input  logic [`JO_BYTE_W-1:0] byte_i,
    input  logic                  frame_active_i,
    output int                    errors_o,
    output int                    checked_o
);
    import jpeg_out_pkg::*;

    bit         pending [$];
    logic [7:0] expected [$];
    int         errors = 0;
    int         checked = 0;
    logic       in_reset_q = 1'b1;
    logic       active_q = 1'b0;
    logic       ff_q = 1'b0;
    logic [7:0] exp_byte;

    assign errors_o  = errors;
    assign checked_o = checked;

    //////////////////////////////
    // model
    //////////////////////////////

    task automatic push_word(input word_t w);
        int         k;
        logic [7:0] b;
        for (k = 0; k < 4; k++) begin
            b = w[31 - 8 * k -: 8];
            expected.push_back(b);
            if (b == 8'hff) begin
                expected.push_back(8'h00);
            end
        end
    endtask

    task automatic take_words();
        int    k;
        word_t w;
        while (pending.size() >= 32) begin
            for (k = 0; k < 32; k++) begin
                w[31 - k] = pending.pop_front();
            end
            push_word(w);
        end
    endtask

    task automatic add_code(input code_t c);
        int k;
        for (k = int'(c.len) - 1; k >= 0; k--) begin
            pending.push_back(c.bits[k]);
        end
        take_words();
    endtask

    // an empty packer still gets a whole word of ones
    task automatic close_frame();
        while (pending.size() < 32) begin
            pending.push_back(1'b1);
        end
        take_words();
        pending.delete();
    endtask

    //////////////////////////////
    // compare
    //////////////////////////////

    always @(negedge clock) begin
        if (nreset) begin
            pending.delete();
            expected.delete();
            active_q = 1'b0;
            ff_q     = 1'b0;
        end else begin
            if (in_reset_q && byte_valid_i !== 1'b0) begin
                $display("[FAIL] %0t byte_valid_o expected 0 actual %b", $time, byte_valid_i);
                errors++;
            end
            if (in_reset_q && frame_active_i !== 1'b0) begin
                $display("[FAIL] %0t frame_active_o expected 0 actual %b", $time,
                         frame_active_i);
                errors++;
            end
            if (ff_q && byte_valid_i !== 1'b1) begin
                $display("[FAIL] %0t byte_valid_o expected 1 actual %b", $time, byte_valid_i);
                errors++;
            end
            if (byte_valid_i) begin
                if (frame_active_i !== 1'b1) begin
                    $display("[FAIL] %0t frame_active_o expected 1 actual %b", $time,
                             frame_active_i);
                    errors++;
                end
                if (expected.size() == 0) begin
                    $display("%0t: extra byte 0x%02h with none expected", $time, byte_i);
                    errors++;
                end else begin
                    exp_byte = expected.pop_front();
                    checked++;
                    if (byte_i !== exp_byte) begin
                        $display("[FAIL] %0t byte_o expected 0x%02h actual 0x%02h",
                                 $time, exp_byte, byte_i);
                        errors++;
                    end
                end
            end
            ff_q = byte_valid_i && (byte_i == 8'hff);
            if (active_q && !frame_active_i && expected.size() != 0) begin
                $display("%0t: frame ended with %0d bytes still missing", $time,
                         expected.size());
                errors++;
            end
            active_q = frame_active_i;
            if (code_valid_i) begin
                add_code(code_i);
            end
            if (frame_done_i) begin
                close_frame();
            end
        end
        in_reset_q = nreset;
    end

endmodule

`default_nettype wire

// ==== dv/tb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "jpeg_out_defines.svh"

module tb_top;
    import jpeg_out_pkg::*;

    localparam int seed            = 32;
    localparam int frames          = 3;
    localparam int codes_per_frame = 40;
    localparam int min_gap         = 8;
    localparam int max_gap         = 12;
    localparam int clk_period      = 20;
    localparam int drive_delay     = 2;
    // every code at the widest gap, then per frame the end wait and a full drain, plus margin
    localparam int limit_cycles    = frames * codes_per_frame * max_gap
                                   + frames * (`JO_DRAIN_CYCLES + 4 * min_gap) + 500;

    logic                  clock;
    logic                  nreset;
    logic                  code_valid;
    code_t                 code;
    logic                  frame_done;
    logic                  byte_valid;
    logic [`JO_BYTE_W-1:0] out_byte;
    logic                  frame_active;
    int                    model_errors;
    int                    checked_bytes;
    int                    assert_errors;

    initial clock = 1'b0;
    always #(clk_period / 2) clock = ~clock;

    jpeg_stream_out DUT (
        .clock          (clock),
        .nreset         (nreset),
        .code_valid_i   (code_valid),
        .code_i         (code),
        .frame_done_i   (frame_done),
        .byte_valid_o   (byte_valid),
        .byte_o         (out_byte),
        .frame_active_o (frame_active)
    );

    stream_checker u_checker (
        .clock          (clock),
        .nreset         (nreset),
        .code_valid_i   (code_valid),
        .code_i         (code),
        .frame_done_i   (frame_done),
        .byte_valid_i   (byte_valid),
        .byte_i         (out_byte),
        .frame_active_i (frame_active),
        .errors_o       (model_errors),
        .checked_o      (checked_bytes)
    );

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // one code strobe, then idle so the next strobe lands gap cycles later
    task automatic send_code(input int len, input logic [31:0] bits, input int gap);
        @(posedge clock);
        #drive_delay;
        code_valid = 1'b1;
        code.len   = `JO_CODE_LEN_W'(len);
        code.bits  = bits;
        @(posedge clock);
        #drive_delay;
        code_valid = 1'b0;
        repeat (gap - 2) @(posedge clock);
    endtask

    task automatic end_frame();
        repeat (min_gap) @(posedge clock);
        #drive_delay;
        frame_done = 1'b1;
        @(posedge clock);
        #drive_delay;
        frame_done = 1'b0;
        // the pad word alone is enough to raise the flag, so both waits end
        while (frame_active !== 1'b1) @(negedge clock);
        while (frame_active !== 1'b0) @(negedge clock);
    endtask

    // kind 0 is plain random, kind 1 sends only ones, kind 2 ends on a word boundary
    task automatic run_frame(input int kind);
        int          n;
        int          len;
        int          fill;
        int          gap;
        logic [31:0] bits;
        fill = 0;
        for (n = 0; n < codes_per_frame; n++) begin
            len  = 1 + int'($urandom % 32);
            bits = $urandom;
            if (kind == 1) begin
                bits = '1;
            end
            if (kind == 2 && n == codes_per_frame - 1) begin
                len = 32 - fill;
            end
            fill = (fill + len) % 32;
            gap  = min_gap + int'($urandom % (max_gap - min_gap + 1));
            send_code(len, bits, gap);
        end
        end_frame();
    endtask

    //////////////////////////////
    // watchdog
    //////////////////////////////

    initial begin
        #(limit_cycles * clk_period);
        $display("timeout after %0d cycles, the DUT never finished its frames", limit_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        void'($urandom(seed));
        nreset     = 1'b1;
        code_valid = 1'b0;
        code       = '0;
        frame_done = 1'b0;
        repeat (5) @(posedge clock);
        #drive_delay;
        nreset = 1'b0;
        repeat (3) @(posedge clock);

        run_frame(0);
        run_frame(1);
        run_frame(2);
        repeat (10) @(posedge clock);

        assert_errors = DUT.u_assert.fail_count;
        $display("checked %0d bytes, %0d model errors, %0d assertion errors",
                 checked_bytes, model_errors, assert_errors);
        if (model_errors == 0 && assert_errors == 0 && checked_bytes > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+logic
logic/jpeg_out_pkg.sv
logic/bit_packer.sv
logic/frame_end_ctrl.sv
logic/word_to_byte.sv
logic/byte_stuffer.sv
logic/jpeg_stream_out.sv
dv/stream_assert.sv
dv/stream_checker.sv
dv/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f tb.f -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if grep -qx '>>> PASS' <<< "$output"; then
    exit 0
else
    exit 1
fi
